/* source/ex_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, operation encodings and payload types of
// the hardened execute stage, referenced as ex_pkg::name
////////////////////////////////////////////////////////////
`default_nettype none

package ex_pkg;

  // Data path and replication
  localparam int XLEN         = 32;
  localparam int NUM_REPLICAS = 3;
  localparam int REG_ADDR_W   = 5;

  typedef logic [XLEN-1:0]         word_t;
  typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
  typedef logic [NUM_REPLICAS-1:0] replica_mask_t;

  // Operation as issued to the stage
  typedef enum logic [4:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
    BEQ, BNE, BLT, BGE,
    MUL, MULH, MULHSU, MULHU
  } ex_op_e;

  // ALU view of the operation
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE
  } alu_op_e;

  // Multiplier view, low word or one of three high words
  typedef enum logic [1:0] {
    MUL_L, MUL_H, MUL_HSU, MUL_HU
  } mult_op_e;

  // ALU replica payload, voted as one unit
  typedef struct packed {
    word_t result;
    logic  cmp;
  } alu_out_t;

endpackage

`default_nettype wire

/* source/ex_op_decode.sv */
////////////////////////////////////////////////////////////
// Operation decode for the execute stage, picks the unit,
// its opcode and the register write enable
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_op_decode (
  input  logic             clk,
  input  ex_pkg::ex_op_e   op_i,
  output ex_pkg::alu_op_e  alu_op_o,
  output ex_pkg::mult_op_e mult_op_o,
  output logic             use_mult_o,
  output logic             is_branch_o,
  output logic             write_en_o
);

  always_comb begin
    alu_op_o    = ex_pkg::ALU_ADD;
    mult_op_o   = ex_pkg::MUL_L;
    use_mult_o  = 1'b0;
    is_branch_o = 1'b0;
    case (op_i)
      ex_pkg::ADD:  alu_op_o = ex_pkg::ALU_ADD;
      ex_pkg::SUB:  alu_op_o = ex_pkg::ALU_SUB;
      ex_pkg::AND:  alu_op_o = ex_pkg::ALU_AND;
      ex_pkg::OR:   alu_op_o = ex_pkg::ALU_OR;
      ex_pkg::XOR:  alu_op_o = ex_pkg::ALU_XOR;
      ex_pkg::SLL:  alu_op_o = ex_pkg::ALU_SLL;
      ex_pkg::SRL:  alu_op_o = ex_pkg::ALU_SRL;
      ex_pkg::SRA:  alu_op_o = ex_pkg::ALU_SRA;
      ex_pkg::SLT:  alu_op_o = ex_pkg::ALU_SLT;
      ex_pkg::SLTU: alu_op_o = ex_pkg::ALU_SLTU;
      // Branches only produce the compare flag
      ex_pkg::BEQ: begin
        alu_op_o    = ex_pkg::ALU_BEQ;
        is_branch_o = 1'b1;
      end
      ex_pkg::BNE: begin
        alu_op_o    = ex_pkg::ALU_BNE;
        is_branch_o = 1'b1;
      end
      ex_pkg::BLT: begin
        alu_op_o    = ex_pkg::ALU_BLT;
        is_branch_o = 1'b1;
      end
      ex_pkg::BGE: begin
        alu_op_o    = ex_pkg::ALU_BGE;
        is_branch_o = 1'b1;
      end
      // Multiplier group
      ex_pkg::MUL: begin
        mult_op_o  = ex_pkg::MUL_L;
        use_mult_o = 1'b1;
      end
      ex_pkg::MULH: begin
        mult_op_o  = ex_pkg::MUL_H;
        use_mult_o = 1'b1;
      end
      ex_pkg::MULHSU: begin
        mult_op_o  = ex_pkg::MUL_HSU;
        use_mult_o = 1'b1;
      end
      ex_pkg::MULHU: begin
        mult_op_o  = ex_pkg::MUL_HU;
        use_mult_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign write_en_o = ~is_branch_o;

  // Undefined encodings would fall back to an ADD with write enable
  a_op_defined : assert property (@(posedge clk) op_i <= ex_pkg::MULHU);

endmodule

`default_nettype wire

/* source/ex_alu.sv */
////////////////////////////////////////////////////////////
// One ALU replica, integer result plus compare flag
// fault_inject_i flips bit 0 and the flag for campaigns
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e  alu_op_i,
  input  ex_pkg::word_t    operand_a_i,
  input  ex_pkg::word_t    operand_b_i,
  input  logic             fault_inject_i,
  output ex_pkg::alu_out_t result_o
);

  logic          [4:0] shamt;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  ex_pkg::word_t       res;
  logic                cmp;

  assign shamt = operand_b_i[4:0];
  assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u  = operand_a_i < operand_b_i;
  assign eq    = operand_a_i == operand_b_i;

  ////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////
  always_comb begin
    res = '0;
    cmp = 1'b0;
    case (alu_op_i)
      ex_pkg::ALU_ADD: res = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: res = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: res = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  res = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: res = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: res = operand_a_i << shamt;
      ex_pkg::ALU_SRL: res = operand_a_i >> shamt;
      ex_pkg::ALU_SRA: res = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than also reports its outcome on the flag
      ex_pkg::ALU_SLT: begin
        res = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
        cmp = lt_s;
      end
      ex_pkg::ALU_SLTU: begin
        res = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
        cmp = lt_u;
      end
      // Branch compares, word stays zero
      ex_pkg::ALU_BEQ: cmp = eq;
      ex_pkg::ALU_BNE: cmp = ~eq;
      ex_pkg::ALU_BLT: cmp = lt_s;
      ex_pkg::ALU_BGE: cmp = ~lt_s;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Fault injection
  ////////////////////////////////////////////////////////////
  assign result_o.result = res ^ {{(ex_pkg::XLEN-1){1'b0}}, fault_inject_i};
  assign result_o.cmp    = cmp ^ fault_inject_i;

endmodule

`default_nettype wire

/* source/ex_mult.sv */
////////////////////////////////////////////////////////////
// One multiplier replica returning the low or high word of
// the 64-bit product, with a bit 0 fault-injection hook
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  ex_pkg::mult_op_e mult_op_i,
  input  ex_pkg::word_t    operand_a_i,
  input  ex_pkg::word_t    operand_b_i,
  input  logic             fault_inject_i,
  output ex_pkg::word_t    result_o
);

  logic                              sign_a;
  logic                              sign_b;
  logic signed [ex_pkg::XLEN:0]      op_a_ext;
  logic signed [ex_pkg::XLEN:0]      op_b_ext;
  logic signed [2*ex_pkg::XLEN+1:0]  prod_full;
  ex_pkg::word_t                     res;

  // Operand signedness per opcode
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    case (mult_op_i)
      ex_pkg::MUL_L, ex_pkg::MUL_H: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      ex_pkg::MUL_HSU: sign_a = 1'b1;
      default: ;
    endcase
  end

  // One extra bit makes every mix a signed 33x33 product
  assign op_a_ext  = {sign_a & operand_a_i[ex_pkg::XLEN-1], operand_a_i};
  assign op_b_ext  = {sign_b & operand_b_i[ex_pkg::XLEN-1], operand_b_i};
  assign prod_full = op_a_ext * op_b_ext;

  assign res = (mult_op_i == ex_pkg::MUL_L) ? prod_full[ex_pkg::XLEN-1:0]
                                            : prod_full[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

  assign result_o = res ^ {{(ex_pkg::XLEN-1){1'b0}}, fault_inject_i};

endmodule

`default_nettype wire

/* source/tmr_voter.sv */
////////////////////////////////////////////////////////////
// Majority voter over the replica payloads of one unit,
// with a flag raised on any disagreement
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t replicas_i [ex_pkg::NUM_REPLICAS],
  output payload_t voted_o,
  output logic     mismatch_o
);

  logic r0_agrees;
  int unsigned vote_hits;
  int unsigned backers;
  logic        majority;

  // Replica 0 wins when any other copy backs it, else replica 1
  always_comb begin
    r0_agrees  = 1'b0;
    mismatch_o = 1'b0;
    for (int k = 1; k < ex_pkg::NUM_REPLICAS; k++) begin
      if (replicas_i[k] == replicas_i[0]) begin
        r0_agrees = 1'b1;
      end else begin
        mismatch_o = 1'b1;
      end
    end
    voted_o = r0_agrees ? replicas_i[0] : replicas_i[1];
  end

  // Copies backing the vote, and whether any value holds a majority
  always_comb begin
    vote_hits = 0;
    majority  = 1'b0;
    for (int j = 0; j < ex_pkg::NUM_REPLICAS; j++) begin
      if (voted_o == replicas_i[j]) begin
        vote_hits++;
      end
      backers = 0;
      for (int k = 0; k < ex_pkg::NUM_REPLICAS; k++) begin
        if (replicas_i[k] == replicas_i[j]) begin
          backers++;
        end
      end
      if (backers > ex_pkg::NUM_REPLICAS / 2) begin
        majority = 1'b1;
      end
    end
  end

  // A majority value always wins, otherwise the vote is still a real copy
  a_vote_majority : assert property (@(posedge clk) disable iff (!rst_n)
    majority ? (vote_hits > ex_pkg::NUM_REPLICAS / 2) : (vote_hits != 0));

endmodule

`default_nettype wire

/* source/ex_wb_reg.sv */
////////////////////////////////////////////////////////////
// EX/WB register, selects the voted unit result and holds
// it under valid/ready flow control, one item at a time
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid_i,
  input  logic              write_en_i,
  input  logic              is_branch_i,
  input  logic              use_mult_i,
  input  ex_pkg::reg_addr_t rd_i,
  input  ex_pkg::alu_out_t  alu_res_i,
  input  logic              alu_mismatch_i,
  input  ex_pkg::word_t     mult_res_i,
  input  logic              mult_mismatch_i,
  input  logic              wb_ready_i,
  output logic              in_ready_o,
  output logic              wb_valid_o,
  output logic              wb_we_o,
  output ex_pkg::reg_addr_t wb_rd_o,
  output ex_pkg::word_t     wb_data_o,
  output logic              branch_taken_o,
  output logic              fault_detected_o
);

  logic          accept;
  ex_pkg::word_t unit_res;
  ex_pkg::word_t data_d;
  logic          taken_d;
  logic          fault_d;

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////
  assign unit_res = use_mult_i ? mult_res_i : alu_res_i.result;
  assign data_d   = is_branch_i ? '0 : unit_res;
  assign taken_d  = is_branch_i & alu_res_i.cmp;
  assign fault_d  = use_mult_i ? mult_mismatch_i : alu_mismatch_i;

  ////////////////////////////////////////////////////////////
  // Flow control and pipeline register
  ////////////////////////////////////////////////////////////
  // Free slot, or the held result leaves this cycle
  assign in_ready_o = ~wb_valid_o | wb_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o       <= 1'b0;
      wb_we_o          <= 1'b0;
      wb_rd_o          <= '0;
      wb_data_o        <= '0;
      branch_taken_o   <= 1'b0;
      fault_detected_o <= 1'b0;
    end else if (accept) begin
      wb_valid_o       <= 1'b1;
      wb_we_o          <= write_en_i;
      wb_rd_o          <= rd_i;
      wb_data_o        <= data_d;
      branch_taken_o   <= taken_d;
      fault_detected_o <= fault_d;
    end else if (wb_ready_i) begin
      wb_valid_o <= 1'b0;
    end
  end

  // Back-pressure freezes the whole output bundle
  a_hold_on_stall : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_we_o) && $stable(wb_rd_o) &&
      $stable(wb_data_o) && $stable(branch_taken_o) && $stable(fault_detected_o)));

endmodule

`default_nettype wire

/* source/ex_stage_top.sv */
////////////////////////////////////////////////////////////
// Hardened execute stage top, triplicated ALU and
// multiplier, majority vote and EX/WB register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid_i,
  input  ex_pkg::ex_op_e        op_i,
  input  ex_pkg::word_t         operand_a_i,
  input  ex_pkg::word_t         operand_b_i,
  input  ex_pkg::reg_addr_t     rd_i,
  input  ex_pkg::replica_mask_t fault_mask_i,
  input  logic                  wb_ready_i,
  output logic                  in_ready_o,
  output logic                  wb_valid_o,
  output logic                  wb_we_o,
  output ex_pkg::reg_addr_t     wb_rd_o,
  output ex_pkg::word_t         wb_data_o,
  output logic                  branch_taken_o,
  output logic                  fault_detected_o
);

  ex_pkg::alu_op_e  alu_op;
  ex_pkg::mult_op_e mult_op;
  logic             use_mult;
  logic             is_branch;
  logic             write_en;

  ex_pkg::alu_out_t alu_res  [ex_pkg::NUM_REPLICAS];
  ex_pkg::word_t    mult_res [ex_pkg::NUM_REPLICAS];
  ex_pkg::alu_out_t alu_voted;
  ex_pkg::word_t    mult_voted;
  logic             alu_mismatch;
  logic             mult_mismatch;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  ex_op_decode i_ex_op_decode (
    .clk         (clk),
    .op_i        (op_i),
    .alu_op_o    (alu_op),
    .mult_op_o   (mult_op),
    .use_mult_o  (use_mult),
    .is_branch_o (is_branch),
    .write_en_o  (write_en)
  );

  ////////////////////////////////////////////////////////////
  // Replicated units, each with its own mask bit
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < ex_pkg::NUM_REPLICAS; i++) begin : gen_replica
    ex_alu i_ex_alu (
      .alu_op_i       (alu_op),
      .operand_a_i    (operand_a_i),
      .operand_b_i    (operand_b_i),
      .fault_inject_i (fault_mask_i[i]),
      .result_o       (alu_res[i])
    );

    ex_mult i_ex_mult (
      .mult_op_i      (mult_op),
      .operand_a_i    (operand_a_i),
      .operand_b_i    (operand_b_i),
      .fault_inject_i (fault_mask_i[i]),
      .result_o       (mult_res[i])
    );
  end

  // Voters
  tmr_voter #(.payload_t(ex_pkg::alu_out_t)) i_alu_voter (
    .clk        (clk),
    .rst_n      (rst_n),
    .replicas_i (alu_res),
    .voted_o    (alu_voted),
    .mismatch_o (alu_mismatch)
  );

  tmr_voter #(.payload_t(ex_pkg::word_t)) i_mult_voter (
    .clk        (clk),
    .rst_n      (rst_n),
    .replicas_i (mult_res),
    .voted_o    (mult_voted),
    .mismatch_o (mult_mismatch)
  );

  ////////////////////////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////////////////////////
  ex_wb_reg i_ex_wb_reg (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid_i       (in_valid_i),
    .write_en_i       (write_en),
    .is_branch_i      (is_branch),
    .use_mult_i       (use_mult),
    .rd_i             (rd_i),
    .alu_res_i        (alu_voted),
    .alu_mismatch_i   (alu_mismatch),
    .mult_res_i       (mult_voted),
    .mult_mismatch_i  (mult_mismatch),
    .wb_ready_i       (wb_ready_i),
    .in_ready_o       (in_ready_o),
    .wb_valid_o       (wb_valid_o),
    .wb_we_o          (wb_we_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .branch_taken_o   (branch_taken_o),
    .fault_detected_o (fault_detected_o)
  );

endmodule

`default_nettype wire

/* tb/tb_ex_stage.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the hardened execute stage, runs
// every operation with and without injected replica faults
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

  localparam int TIMEOUT_CYCLES = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  ex_pkg::ex_op_e        op;
  ex_pkg::word_t         operand_a;
  ex_pkg::word_t         operand_b;
  ex_pkg::reg_addr_t     rd;
  ex_pkg::replica_mask_t fault_mask;
  logic                  wb_ready;
  logic                  in_ready;
  logic                  wb_valid;
  logic                  wb_we;
  ex_pkg::reg_addr_t     wb_rd;
  ex_pkg::word_t         wb_data;
  logic                  branch_taken;
  logic                  fault_detected;

  logic [31:0]   lcg_state;
  ex_pkg::word_t edge_vals [5] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'h1};

  ex_stage_top i_ex_stage_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid_i       (in_valid),
    .op_i             (op),
    .operand_a_i      (operand_a),
    .operand_b_i      (operand_b),
    .rd_i             (rd),
    .fault_mask_i     (fault_mask),
    .wb_ready_i       (wb_ready),
    .in_ready_o       (in_ready),
    .wb_valid_o       (wb_valid),
    .wb_we_o          (wb_we),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data),
    .branch_taken_o   (branch_taken),
    .fault_detected_o (fault_detected)
  );

  always #5 clk = ~clk;

  function automatic ex_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of one fault-free instruction
  ////////////////////////////////////////////////////////////
  function automatic void ref_model(input ex_pkg::ex_op_e op_m, input ex_pkg::word_t a,
                                    input ex_pkg::word_t b, output ex_pkg::word_t data,
                                    output logic we, output logic taken);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] za;
    logic [63:0] zb;
    logic [63:0] wide;
    logic        lt_signed;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    za = {32'h0, a};
    zb = {32'h0, b};
    // Flipping the sign bits turns a signed compare into an unsigned one
    lt_signed = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    data  = '0;
    we    = 1'b1;
    taken = 1'b0;
    wide  = '0;
    case (op_m)
      ex_pkg::ADD:  data = a + b;
      ex_pkg::SUB:  data = a + ~b + 32'd1;
      ex_pkg::AND:  data = a & b;
      ex_pkg::OR:   data = a | b;
      ex_pkg::XOR:  data = a ^ b;
      ex_pkg::SLL:  data = a << b[4:0];
      ex_pkg::SRL:  data = a >> b[4:0];
      ex_pkg::SRA: begin
        wide = sa >> b[4:0];
        data = wide[31:0];
      end
      ex_pkg::SLT:  data = {31'h0, lt_signed};
      ex_pkg::SLTU: data = {31'h0, a < b};
      ex_pkg::BEQ:  taken = (a == b);
      ex_pkg::BNE:  taken = (a != b);
      ex_pkg::BLT:  taken = lt_signed;
      ex_pkg::BGE:  taken = ~lt_signed;
      ex_pkg::MUL: begin
        wide = sa * sb;
        data = wide[31:0];
      end
      ex_pkg::MULH: begin
        wide = sa * sb;
        data = wide[63:32];
      end
      ex_pkg::MULHSU: begin
        wide = sa * zb;
        data = wide[63:32];
      end
      ex_pkg::MULHU: begin
        wide = za * zb;
        data = wide[63:32];
      end
      default: ;
    endcase
    if (op_m inside {ex_pkg::BEQ, ex_pkg::BNE, ex_pkg::BLT, ex_pkg::BGE}) begin
      we = 1'b0;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input ex_pkg::word_t exp, input ex_pkg::word_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input ex_pkg::reg_addr_t exp,
                            input ex_pkg::reg_addr_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driving and waiting
  ////////////////////////////////////////////////////////////
  task automatic drive_instr(input ex_pkg::ex_op_e op_d, input ex_pkg::word_t a,
                             input ex_pkg::word_t b, input ex_pkg::reg_addr_t rd_d,
                             input ex_pkg::replica_mask_t mask);
    in_valid   = 1'b1;
    op         = op_d;
    operand_a  = a;
    operand_b  = b;
    rd         = rd_d;
    fault_mask = mask;
  endtask

  // Returns 1 ns after the accepting edge with in_valid dropped
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!in_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timed out waiting for in_ready_o to accept an instruction");
        abort_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_result();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!wb_valid) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timed out waiting for wb_valid_o after an accepted instruction");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic verify_outputs(input ex_pkg::ex_op_e op_v, input ex_pkg::word_t a,
                                input ex_pkg::word_t b, input ex_pkg::reg_addr_t rd_v,
                                input ex_pkg::replica_mask_t mask);
    ex_pkg::word_t exp_data;
    logic          exp_we;
    logic          exp_taken;
    logic          exp_fault;
    int            faults;
    ref_model(op_v, a, b, exp_data, exp_we, exp_taken);
    faults    = $countones(mask);
    exp_fault = (faults != 0) && (faults != ex_pkg::NUM_REPLICAS);
    // Two faulty copies outvote the clean one
    if (faults >= 2) begin
      if (exp_we) begin
        exp_data[0] = ~exp_data[0];
      end else begin
        exp_taken = ~exp_taken;
      end
    end
    check_bit("wb_valid_o", 1'b1, wb_valid);
    check_bit("wb_we_o", exp_we, wb_we);
    check_addr("wb_rd_o", rd_v, wb_rd);
    check_word("wb_data_o", exp_data, wb_data);
    check_bit("branch_taken_o", exp_taken, branch_taken);
    check_bit("fault_detected_o", exp_fault, fault_detected);
  endtask

  task automatic run_op(input ex_pkg::ex_op_e op_r, input ex_pkg::word_t a,
                        input ex_pkg::word_t b, input ex_pkg::replica_mask_t mask);
    ex_pkg::reg_addr_t rd_r;
    rd_r = ex_pkg::reg_addr_t'(lcg_next());
    @(posedge clk);
    #1;
    drive_instr(op_r, a, b, rd_r, mask);
    wait_accept();
    wait_result();
    verify_outputs(op_r, a, b, rd_r, mask);
  endtask

  // Edge operand grid, random pairs and random equal pairs per operation
  task automatic sweep_ops(input int first, input int last, input ex_pkg::replica_mask_t mask);
    ex_pkg::ex_op_e op_s;
    ex_pkg::word_t  a;
    ex_pkg::word_t  b;
    for (int k = first; k <= last; k++) begin
      op_s = ex_pkg::ex_op_e'(k);
      foreach (edge_vals[i]) begin
        foreach (edge_vals[j]) begin
          run_op(op_s, edge_vals[i], edge_vals[j], mask);
        end
      end
      for (int n = 0; n < 6; n++) begin
        a = lcg_next();
        b = lcg_next();
        run_op(op_s, a, b, mask);
        run_op(op_s, a, a, mask);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic after_reset();
    @(negedge clk);
    check_bit("wb_valid_o", 1'b0, wb_valid);
    check_bit("wb_we_o", 1'b0, wb_we);
    check_bit("branch_taken_o", 1'b0, branch_taken);
    check_bit("fault_detected_o", 1'b0, fault_detected);
    check_bit("in_ready_o", 1'b1, in_ready);
  endtask

  task automatic alu_ops();
    sweep_ops(int'(ex_pkg::ADD), int'(ex_pkg::SLTU), '0);
  endtask

  task automatic mult_ops();
    sweep_ops(int'(ex_pkg::MUL), int'(ex_pkg::MULHU), '0);
  endtask

  task automatic branch_ops();
    sweep_ops(int'(ex_pkg::BEQ), int'(ex_pkg::BGE), '0);
  endtask

  task automatic single_faults();
    for (int m = 0; m < ex_pkg::NUM_REPLICAS; m++) begin
      sweep_ops(int'(ex_pkg::ADD), int'(ex_pkg::MULHU), ex_pkg::replica_mask_t'(1 << m));
    end
  endtask

  task automatic double_faults();
    sweep_ops(int'(ex_pkg::ADD), int'(ex_pkg::MULHU), 3'b011);
    sweep_ops(int'(ex_pkg::ADD), int'(ex_pkg::MULHU), 3'b101);
    sweep_ops(int'(ex_pkg::ADD), int'(ex_pkg::MULHU), 3'b110);
  endtask

  task automatic backpressure();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    ex_pkg::word_t c;
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    @(posedge clk);
    #1;
    wb_ready = 1'b0;
    drive_instr(ex_pkg::MULHU, a, b, 5'd7, '0);
    wait_accept();
    wait_result();
    verify_outputs(ex_pkg::MULHU, a, b, 5'd7, '0);
    // Next instruction waits at the input during the stall
    @(posedge clk);
    #1;
    drive_instr(ex_pkg::XOR, c, a, 5'd19, '0);
    repeat (5) begin
      @(negedge clk);
      check_bit("in_ready_o", 1'b0, in_ready);
      verify_outputs(ex_pkg::MULHU, a, b, 5'd7, '0);
    end
    @(posedge clk);
    #1;
    wb_ready = 1'b1;
    wait_accept();
    wait_result();
    verify_outputs(ex_pkg::XOR, c, a, 5'd19, '0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    op         = ex_pkg::ADD;
    operand_a  = '0;
    operand_b  = '0;
    rd         = '0;
    fault_mask = '0;
    wb_ready   = 1'b1;
    lcg_state  = 32'd76;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    after_reset();
    alu_ops();
    mult_ops();
    branch_ops();
    single_faults();
    double_faults();
    backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
source/ex_pkg.sv
source/ex_op_decode.sv
source/ex_alu.sv
source/ex_mult.sv
source/tmr_voter.sv
source/ex_wb_reg.sv
source/ex_stage_top.sv
tb/tb_ex_stage.sv
